// File: hdl/loopPkg.sv
//////////////////////////////////////////////////
// Shared definitions of the carrier loop filter
//   Phase error, gain exponent and loop word types
//   Gain scheduler state encoding
//   Saturation limits of the 40-bit loop word
//////////////////////////////////////////////////

package loopPkg;

    localparam int ERROR_W = 8;   // Phase detector output width
    localparam int EXP_W = 5;
    localparam int LOOP_W = 40;   // NCO control word width

    // Signed phase error, one per sample strobe
    typedef logic signed [ERROR_W-1:0] errorT;

    // Power-of-two gain exponent, 0 turns the path off
    typedef logic [EXP_W-1:0] expT;

    // Lead word, lag accumulator and filter output
    typedef logic signed [LOOP_W-1:0] loopWordT;

    // Gain scheduler states
    typedef enum logic [1:0] {
        ACQUIRE = 2'd0,   // Wide gains while pulling in
        TRACK = 2'd1,     // Narrow gains once locked
        HOLD = 2'd2       // Both paths stopped
    } loopStateT;

    // Largest and smallest signed loop words
    localparam loopWordT LOOP_MAX = {1'b0, {(LOOP_W - 1){1'b1}}};
    localparam loopWordT LOOP_MIN = {1'b1, {(LOOP_W - 1){1'b0}}};

endpackage

// File: hdl/leadGain.sv
//////////////////////////////////////////////////
// Proportional (lead) path of the loop filter
//   Error scaled by a power-of-two exponent
//   Registered into a 40-bit lead word
//////////////////////////////////////////////////

`timescale 1ns/10ps

module leadGain (
    input  logic              clk,
    input  logic              reset,
    input  logic              clkEn,
    input  loopPkg::errorT    error,
    input  loopPkg::expT      leadExp,
    output loopPkg::loopWordT leadError
);

    logic [5:0] leadShift;         // Needs 6 bits, exponent 31 shifts by 32
    loopPkg::loopWordT errorExt;

    // Exponent n places the error n+1 bits up
    assign leadShift = {1'b0, leadExp} + 6'd1;
    assign errorExt = loopPkg::loopWordT'(error);   // Sign extension

    always_ff @(posedge clk) begin
        if (reset) begin
            leadError <= '0;
        end else if (clkEn) begin
            if (leadExp == '0) begin
                leadError <= '0;   // Lead path off
            end else begin
                leadError <= errorExt <<< leadShift;
            end
        end
    end

    // An exponent of zero must leave nothing in the lead word on the next step
    leadOffClears: assert property (
        @(posedge clk) disable iff (reset)
        (clkEn && leadExp == '0) |=> (leadError == '0)
    ) else $error("leadError not cleared after leadExp of zero");

endmodule

// File: hdl/integralPath.sv
//////////////////////////////////////////////////
// Integral (lag) path of the loop filter
//   Saturating lag accumulator
//   Saturating sum of lead word and lag accumulator
//   into the registered filter output
//////////////////////////////////////////////////

`timescale 1ns/10ps

module integralPath (
    input  logic              clk,
    input  logic              reset,
    input  logic              clkEn,
    input  loopPkg::errorT    error,
    input  loopPkg::expT      lagExp,
    input  loopPkg::loopWordT leadError,
    output loopPkg::loopWordT loopOut
);

    loopPkg::loopWordT lagAcc;
    loopPkg::loopWordT lagStep;     // Scaled error added each step
    logic [5:0] lagShift;

    // Signed add clamped to the loop word range
    function automatic loopPkg::loopWordT satAdd(
        input loopPkg::loopWordT a,
        input loopPkg::loopWordT b
    );
        logic [40:0] sum;
        sum = {a[39], a} + {b[39], b};
        // Top two bits differ only on overflow
        if (sum[40] != sum[39]) begin
            return sum[40] ? loopPkg::LOOP_MIN : loopPkg::LOOP_MAX;
        end
        return sum[39:0];
    endfunction

    assign lagShift = {1'b0, lagExp} + 6'd1;

    always_comb begin
        if (lagExp == '0) begin
            lagStep = '0;   // Integrator holds
        end else begin
            lagStep = loopPkg::loopWordT'(error) <<< lagShift;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lagAcc <= '0;
            loopOut <= '0;
        end else if (clkEn) begin
            lagAcc <= satAdd(lagAcc, lagStep);
            loopOut <= satAdd(leadError, lagAcc);   // Old lagAcc, aligned with leadError
        end
    end

    // Frozen or off lag path must keep the integrator value across the step
    lagHoldsWhenOff: assert property (
        @(posedge clk) disable iff (reset)
        (clkEn && lagExp == '0) |=> $stable(lagAcc)
    ) else $error("lagAcc changed while lagExp was zero");

endmodule

// File: hdl/gainScheduler.sv
//////////////////////////////////////////////////
// Gain scheduler of the loop filter
//   ACQUIRE / TRACK / HOLD state machine
//   Lead and lag exponent selection
//   Dwell timer enable
//////////////////////////////////////////////////

`timescale 1ns/10ps

module gainScheduler (
    input  logic               clk,
    input  logic               reset,
    input  logic               clkEn,
    input  logic               lockDetect,
    input  logic               freeze,
    input  loopPkg::expT       acqLeadExp,
    input  loopPkg::expT       acqLagExp,
    input  loopPkg::expT       trkLeadExp,
    input  loopPkg::expT       trkLagExp,
    input  logic               dwellDone,
    output logic               timerRun,
    output loopPkg::expT       leadExp,
    output loopPkg::expT       lagExp,
    output loopPkg::loopStateT loopState
);

    loopPkg::loopStateT state;
    loopPkg::loopStateT nextState;

    assign loopState = state;

    // Dwell only counts while still acquiring with lock present
    assign timerRun = (state == loopPkg::ACQUIRE) && lockDetect;

    always_comb begin
        nextState = state;
        if (freeze) begin
            nextState = loopPkg::HOLD;   // Freeze wins in every state
        end else begin
            case (state)
                loopPkg::ACQUIRE: begin
                    if (dwellDone) begin
                        nextState = loopPkg::TRACK;
                    end
                end
                loopPkg::TRACK: begin
                    if (!lockDetect) begin
                        nextState = loopPkg::ACQUIRE;   // Lock lost, widen again
                    end
                end
                default: nextState = loopPkg::ACQUIRE;
            endcase
        end
    end

    // Exponents follow the current state, not the next one
    always_comb begin
        case (state)
            loopPkg::ACQUIRE: begin
                leadExp = acqLeadExp;
                lagExp = acqLagExp;
            end
            loopPkg::TRACK: begin
                leadExp = trkLeadExp;
                lagExp = trkLagExp;
            end
            default: begin
                leadExp = '0;   // HOLD stops both paths
                lagExp = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= loopPkg::ACQUIRE;
        end else if (clkEn) begin
            state <= nextState;
        end
    end

    trackOnlyFromAcquire: assert property (
        @(posedge clk) disable iff (reset)
        (state == loopPkg::TRACK && $past(state) != loopPkg::TRACK)
            |-> ($past(state) == loopPkg::ACQUIRE)
    ) else $error("TRACK entered from a state other than ACQUIRE");

endmodule

// File: hdl/dwellTimer.sv
//////////////////////////////////////////////////
// Lock dwell timer
//   Counts consecutive locked sample strobes
//   Flags the last strobe of the dwell
//////////////////////////////////////////////////

`timescale 1ns/10ps

module dwellTimer #(
    parameter int DWELL_LEN = 16   // Strobes of lock before tracking, 2 or more
) (
    input  logic clk,
    input  logic reset,
    input  logic clkEn,
    input  logic timerRun,
    output logic dwellDone
);

    localparam int CNT_W = $clog2(DWELL_LEN);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(DWELL_LEN - 1);

    logic [CNT_W-1:0] count;

    assign dwellDone = timerRun && (count == LAST);

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (clkEn) begin
            if (!timerRun || dwellDone) begin
                count <= '0;   // Lock dropped or dwell complete
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    countInRange: assert property (
        @(posedge clk) disable iff (reset)
        count <= LAST
    ) else $error("dwell count past DWELL_LEN-1");

endmodule

// File: hdl/loopFilter.sv
//////////////////////////////////////////////////
// Carrier recovery loop filter, top level
//   Gain scheduler and dwell timer
//   Lead path and lag path into the NCO control word
//////////////////////////////////////////////////

`timescale 1ns/10ps

module loopFilter #(
    parameter int DWELL_LEN = 16
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               clkEn,        // Sample strobe
    input  loopPkg::errorT     error,
    input  logic               lockDetect,
    input  logic               freeze,
    input  loopPkg::expT       acqLeadExp,
    input  loopPkg::expT       acqLagExp,
    input  loopPkg::expT       trkLeadExp,
    input  loopPkg::expT       trkLagExp,
    output loopPkg::loopWordT  loopOut,      // To the NCO
    output loopPkg::loopStateT loopState
);

    loopPkg::expT leadExp;
    loopPkg::expT lagExp;
    loopPkg::loopWordT leadError;
    logic timerRun;
    logic dwellDone;

    gainScheduler gainScheduler_inst (
        .clk        (clk),
        .reset      (reset),
        .clkEn      (clkEn),
        .lockDetect (lockDetect),
        .freeze     (freeze),
        .acqLeadExp (acqLeadExp),
        .acqLagExp  (acqLagExp),
        .trkLeadExp (trkLeadExp),
        .trkLagExp  (trkLagExp),
        .dwellDone  (dwellDone),
        .timerRun   (timerRun),
        .leadExp    (leadExp),
        .lagExp     (lagExp),
        .loopState  (loopState)
    );

    dwellTimer #(
        .DWELL_LEN (DWELL_LEN)
    ) dwellTimer_inst (
        .clk       (clk),
        .reset     (reset),
        .clkEn     (clkEn),
        .timerRun  (timerRun),
        .dwellDone (dwellDone)
    );

    leadGain leadGain_inst (
        .clk       (clk),
        .reset     (reset),
        .clkEn     (clkEn),
        .error     (error),
        .leadExp   (leadExp),
        .leadError (leadError)
    );

    // Lag path also forms the output sum
    integralPath integralPath_inst (
        .clk       (clk),
        .reset     (reset),
        .clkEn     (clkEn),
        .error     (error),
        .lagExp    (lagExp),
        .leadError (leadError),
        .loopOut   (loopOut)
    );

endmodule

// File: testbench/loopFilterTb.sv
//////////////////////////////////////////////////
// Testbench of the carrier loop filter
//   Random stimulus from a fixed seed
//   Cycle-accurate model of both paths and the scheduler
//   Compare tasks on every cycle, cycle timeout
//////////////////////////////////////////////////

`timescale 1ns/10ps

module loopFilterTb;

    localparam int DWELL_LEN = 16;
    localparam int RESET_LEN = 5;
    localparam int SWEEP_LEN = 12;      // Cycles per lead exponent
    localparam int RAND_PHASES = 6;
    localparam int RAND_LEN = 40;
    localparam int SAT_LEN = 60;        // Per error sign
    localparam int LOCK_SHORT = 8;      // Always shorter than the dwell
    localparam int LOCK_GAP = 4;
    localparam int DWELL_WAIT = 100;    // Dwell allowance with clkEn gaps
    localparam int TRACK_LEN = 40;
    localparam int DROP_LEN = 20;
    localparam int FREEZE_LEN = 30;
    localparam int RELEASE_LEN = 20;
    localparam int TEST_LEN = RESET_LEN + 32 * SWEEP_LEN + RAND_PHASES * RAND_LEN
        + 2 * SAT_LEN + LOCK_SHORT + LOCK_GAP + DWELL_WAIT + TRACK_LEN + DROP_LEN
        + FREEZE_LEN + RELEASE_LEN;
    localparam int TIMEOUT = 2 * TEST_LEN;

    // Signed 40-bit range
    localparam longint WORD_MAX = (longint'(1) <<< 39) - 1;
    localparam longint WORD_MIN = -(longint'(1) <<< 39);

    logic clk = 1'b0;
    logic reset;
    logic clkEn;
    loopPkg::errorT error;
    logic lockDetect;
    logic freeze;
    loopPkg::expT acqLeadExp;
    loopPkg::expT acqLagExp;
    loopPkg::expT trkLeadExp;
    loopPkg::expT trkLagExp;
    loopPkg::loopWordT loopOut;
    loopPkg::loopStateT loopState;

    // Model registers
    loopPkg::loopWordT mLeadError;
    loopPkg::loopWordT mLagAcc;
    loopPkg::loopWordT mOut;
    loopPkg::loopStateT mState;
    int mCount;
    int enSteps;                        // Strobes taken since reset

    logic sawMax;
    logic sawMin;
    int cycleCount;
    int errMode;                        // 0 any sign, 1 positive, 2 negative

    always #10 clk = ~clk;

    loopFilter #(
        .DWELL_LEN (DWELL_LEN)
    ) loopFilter_inst (
        .clk        (clk),
        .reset      (reset),
        .clkEn      (clkEn),
        .error      (error),
        .lockDetect (lockDetect),
        .freeze     (freeze),
        .acqLeadExp (acqLeadExp),
        .acqLagExp  (acqLagExp),
        .trkLeadExp (trkLeadExp),
        .trkLagExp  (trkLagExp),
        .loopOut    (loopOut),
        .loopState  (loopState)
    );

    // Gain of 2^(x+1) applied as a product and wrapped to 40 bits
    function automatic loopPkg::loopWordT scaleError(
        input loopPkg::errorT e,
        input loopPkg::expT x
    );
        longint wide;
        wide = longint'(e) * (longint'(1) << (x + 1));
        return wide[39:0];
    endfunction

    function automatic loopPkg::loopWordT satSum(
        input loopPkg::loopWordT a,
        input loopPkg::loopWordT b
    );
        longint s;
        s = longint'(a) + longint'(b);
        if (s > WORD_MAX) begin
            return loopPkg::loopWordT'(WORD_MAX);
        end
        if (s < WORD_MIN) begin
            return loopPkg::loopWordT'(WORD_MIN);
        end
        return loopPkg::loopWordT'(s);
    endfunction

    function automatic loopPkg::errorT randomError(input int mode);
        case (mode)
            1: return loopPkg::errorT'($urandom_range(127, 1));
            2: return loopPkg::errorT'(-int'($urandom_range(128, 1)));
            default: return loopPkg::errorT'($urandom);
        endcase
    endfunction

    function automatic loopPkg::expT randomExp();
        if ($urandom_range(3) == 0) begin
            return '0;   // Path off
        end
        return loopPkg::expT'($urandom_range(31, 1));
    endfunction

    task automatic checkWord(
        input string name,
        input loopPkg::loopWordT got,
        input loopPkg::loopWordT expected
    );
        if (got !== expected) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic checkState(
        input string name,
        input loopPkg::loopStateT got,
        input loopPkg::loopStateT expected
    );
        if (got !== expected) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic checkCount(input string name, input int got, input int expected);
        if (got != expected) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // One clock of per-cycle stimulus
    task automatic stepCycle();
        @(posedge clk);
        clkEn <= ($urandom_range(3) != 0);   // About 3 strobes in 4
        error <= randomError(errMode);
    endtask

    task automatic runCycles(input int n);
        repeat (n) begin
            stepCycle();
        end
    endtask

    task automatic setGains(
        input loopPkg::expT aLead,
        input loopPkg::expT aLag,
        input loopPkg::expT tLead,
        input loopPkg::expT tLag
    );
        acqLeadExp <= aLead;
        acqLagExp <= aLag;
        trkLeadExp <= tLead;
        trkLagExp <= tLag;
    endtask

    always @(posedge clk) begin : modelStep
        loopPkg::expT leadExp;
        loopPkg::expT lagExp;
        logic run;
        logic done;
        loopPkg::loopWordT nextLead;
        loopPkg::loopWordT nextAcc;
        loopPkg::loopStateT nextState;

        if (reset) begin
            mLeadError = '0;
            mLagAcc = '0;
            mOut = '0;
            mState = loopPkg::ACQUIRE;
            mCount = 0;
        end else if (clkEn) begin
            case (mState)
                loopPkg::ACQUIRE: begin
                    leadExp = acqLeadExp;
                    lagExp = acqLagExp;
                end
                loopPkg::TRACK: begin
                    leadExp = trkLeadExp;
                    lagExp = trkLagExp;
                end
                default: begin
                    leadExp = '0;
                    lagExp = '0;
                end
            endcase
            run = (mState == loopPkg::ACQUIRE) && lockDetect;
            done = run && (mCount == DWELL_LEN - 1);
            nextLead = (leadExp == '0) ? '0 : scaleError(error, leadExp);
            nextAcc = (lagExp == '0) ? mLagAcc : satSum(mLagAcc, scaleError(error, lagExp));
            mOut = satSum(mLeadError, mLagAcc);   // Previous lead and lag words
            if (freeze) begin
                nextState = loopPkg::HOLD;
            end else if (mState == loopPkg::ACQUIRE) begin
                nextState = done ? loopPkg::TRACK : loopPkg::ACQUIRE;
            end else if (mState == loopPkg::TRACK) begin
                nextState = lockDetect ? loopPkg::TRACK : loopPkg::ACQUIRE;
            end else begin
                nextState = loopPkg::ACQUIRE;
            end
            mCount = (!run || done) ? 0 : mCount + 1;
            mLeadError = nextLead;
            mLagAcc = nextAcc;
            mState = nextState;
            enSteps++;
        end
    end

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            checkWord("loopOut", loopOut, mOut);
            checkState("loopState", loopState, mState);
            if (loopOut == loopPkg::LOOP_MAX) begin
                sawMax = 1'b1;
            end
            if (loopOut == loopPkg::LOOP_MIN) begin
                sawMin = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > TIMEOUT) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("SOME TESTS FAILED");
            $fatal(1, "Simulation timed out");
        end
    end

    initial begin : phases
        int idx;
        int startSteps;

        void'($urandom(98));
        reset = 1'b1;
        clkEn = 1'b0;
        error = '0;
        lockDetect = 1'b0;
        freeze = 1'b0;
        acqLeadExp = '0;
        acqLagExp = '0;
        trkLeadExp = '0;
        trkLagExp = '0;
        errMode = 0;
        sawMax = 1'b0;
        sawMin = 1'b0;
        runCycles(RESET_LEN);
        reset <= 1'b0;

        // Lead shift for every exponent with the lag path off
        for (idx = 0; idx < 32; idx++) begin
            setGains(loopPkg::expT'(idx), '0, '0, '0);
            runCycles(SWEEP_LEN);
        end

        for (idx = 0; idx < RAND_PHASES; idx++) begin
            setGains(randomExp(), randomExp(), randomExp(), randomExp());
            runCycles(RAND_LEN);
        end

        // Widest lag gain with one error sign at a time
        setGains(randomExp(), 5'd31, '0, '0);
        errMode = 1;
        runCycles(SAT_LEN);
        errMode = 2;
        runCycles(SAT_LEN);
        errMode = 0;

        setGains(randomExp(), randomExp(), randomExp(), randomExp());
        lockDetect <= 1'b1;
        runCycles(LOCK_SHORT);
        lockDetect <= 1'b0;   // Drop before the dwell ends so the count restarts
        runCycles(LOCK_GAP);
        lockDetect <= 1'b1;
        @(negedge clk);
        startSteps = enSteps;
        while (loopState != loopPkg::TRACK) begin
            stepCycle();
            @(negedge clk);
        end
        checkCount("dwell steps", enSteps - startSteps, DWELL_LEN);
        runCycles(TRACK_LEN);
        lockDetect <= 1'b0;
        runCycles(DROP_LEN);

        freeze <= 1'b1;
        runCycles(FREEZE_LEN);
        @(negedge clk);
        checkState("loopState", loopState, loopPkg::HOLD);
        checkWord("loopOut", loopOut, mLagAcc);   // Frozen lag value only
        stepCycle();
        freeze <= 1'b0;
        runCycles(RELEASE_LEN - 1);
        @(negedge clk);

        if (!sawMax || !sawMin) begin
            $display("The lag path never drove loopOut to both saturation limits");
            $display("SOME TESTS FAILED");
            $fatal(1, "Saturation not reached");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

// File: filelist.f
hdl/loopPkg.sv
hdl/leadGain.sv
hdl/integralPath.sv
hdl/gainScheduler.sv
hdl/dwellTimer.sv
hdl/loopFilter.sv
testbench/loopFilterTb.sv

// File: Makefile
# Verilator simulation of the loop filter testbench

.PHONY: all run clean

all: run

obj_dir/VloopFilterTb: filelist.f $(wildcard hdl/*.sv) $(wildcard testbench/*.sv)
	verilator --binary --timing --assert --top-module loopFilterTb -f filelist.f -o VloopFilterTb

run: obj_dir/VloopFilterTb
	-./obj_dir/VloopFilterTb > sim.log 2>&1
	@cat sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir sim.log
